// File: design/alu_exe.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module alu_exe (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              rf_en0, rf_en1,
    input  uop_pkg::uop_op_t  rf_op0, rf_op1,
    input  uop_pkg::reg_idx_t rf_rd0, rf_rd1,
    input  result_pkg::word_t rf_imm0, rf_imm1,
    input  result_pkg::word_t rf_pc0, rf_pc1,
    input  result_pkg::word_t rf_dataj0, rf_datak0,
    input  result_pkg::word_t rf_dataj1, rf_datak1,
    output logic              ex_en0, ex_en1,
    output uop_pkg::reg_idx_t ex_rd0, ex_rd1,
    output result_pkg::word_t ex_data0, ex_data1,
    output result_pkg::word_t ex_pc0, ex_pc1,
    output logic              redirect,
    output result_pkg::word_t redirect_pc
);
    import uop_pkg::*;
    import result_pkg::*;

    localparam int SH_W = $clog2(`XLEN);

    function automatic word_t alu(input uop_op_t op, input word_t a, input word_t b,
                                  input word_t imm);
        word_t res;
        case (op)
            op_add:  res = a + b;
            op_sub:  res = a - b;
            op_and:  res = a & b;
            op_or:   res = a | b;
            op_xor:  res = a ^ b;
            op_sll:  res = a << b[SH_W-1:0];
            op_srl:  res = a >> b[SH_W-1:0];
            op_slt:  res = word_t'($signed(a) < $signed(b));
            op_addi: res = a + imm;
            op_lui:  res = imm;
            default: res = '0;
        endcase
        return res;
    endfunction

    logic br_cond;
    logic br_taken;

    always_comb begin
        case (rf_op0)
            op_beq:  br_cond = (rf_dataj0 == rf_datak0);
            op_bne:  br_cond = (rf_dataj0 != rf_datak0);
            op_blt:  br_cond = ($signed(rf_dataj0) < $signed(rf_datak0));
            default: br_cond = 1'b0;
        endcase
    end

    assign br_taken = rf_en0 && br_cond;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ex_en0   <= 1'b0;
            ex_en1   <= 1'b0;
            redirect <= 1'b0;
        end else if (redirect) begin
            // operand stage holds ops younger than the taken branch
            ex_en0   <= 1'b0;
            ex_en1   <= 1'b0;
            redirect <= 1'b0;
        end else begin
            ex_en0   <= rf_en0 && writes_rd(rf_op0) && (rf_rd0 != '0);
            ex_en1   <= rf_en1 && !br_taken && writes_rd(rf_op1) && (rf_rd1 != '0);
            redirect <= br_taken;
        end
    end

    always_ff @(posedge aclk) begin
        ex_rd0   <= rf_rd0;
        ex_data0 <= alu(rf_op0, rf_dataj0, rf_datak0, rf_imm0);
        ex_pc0   <= rf_pc0;
        ex_rd1   <= rf_rd1;
        ex_data1 <= alu(rf_op1, rf_dataj1, rf_datak1, rf_imm1);
        ex_pc1   <= rf_pc1;
        // target is pc relative
        if (br_taken)
            redirect_pc <= rf_pc0 + rf_imm0;
    end

endmodule

// File: design/core_backend.sv
`timescale 1ns/1ps

module core_backend (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic [1:0]        in_num,
    input  uop_pkg::uop_op_t  in_op0, in_op1,
    input  uop_pkg::reg_idx_t in_rd0, in_rj0, in_rk0,
    input  uop_pkg::reg_idx_t in_rd1, in_rj1, in_rk1,
    input  result_pkg::word_t in_imm0, in_imm1,
    input  result_pkg::word_t in_pc0, in_pc1,
    output logic              full,
    output logic              redirect,
    output result_pkg::word_t redirect_pc,
    output logic              wb_valid0, wb_valid1,
    output uop_pkg::reg_idx_t wb_rd0, wb_rd1,
    output result_pkg::word_t wb_data0, wb_data1,
    output result_pkg::word_t wb_pc0, wb_pc1
);
    import uop_pkg::*;
    import result_pkg::*;

    logic          iss_en0, iss_en1;
    uop_op_t       iss_op0, iss_op1;
    reg_idx_t      iss_rd0, iss_rd1, iss_rj0, iss_rj1, iss_rk0, iss_rk1;
    word_t         iss_imm0, iss_imm1, iss_pc0, iss_pc1;

    logic          rf_en0, rf_en1;
    uop_op_t       rf_op0, rf_op1;
    reg_idx_t      rf_rd0, rf_rd1;
    word_t         rf_imm0, rf_imm1, rf_pc0, rf_pc1;
    word_t         rf_dataj0, rf_datak0, rf_dataj1, rf_datak1;

    logic          ex_en0, ex_en1;
    reg_idx_t      ex_rd0, ex_rd1;
    word_t         ex_data0, ex_data1, ex_pc0, ex_pc1;

    logic          wen0, wen1;
    reg_idx_t      waddr0, waddr1;
    word_t         wdata0, wdata1;
    pending_mask_t release_mask;

    // redirect doubles as the flush of the front stages
    issue_queue u_queue (
        .aclk(aclk), .aresetn(aresetn), .in_num(in_num),
        .in_op0(in_op0), .in_op1(in_op1),
        .in_rd0(in_rd0), .in_rj0(in_rj0), .in_rk0(in_rk0),
        .in_rd1(in_rd1), .in_rj1(in_rj1), .in_rk1(in_rk1),
        .in_imm0(in_imm0), .in_imm1(in_imm1), .in_pc0(in_pc0), .in_pc1(in_pc1),
        .flush(redirect), .release_mask(release_mask), .full(full),
        .iss_en0(iss_en0), .iss_en1(iss_en1), .iss_op0(iss_op0), .iss_op1(iss_op1),
        .iss_rd0(iss_rd0), .iss_rd1(iss_rd1), .iss_rj0(iss_rj0), .iss_rj1(iss_rj1),
        .iss_rk0(iss_rk0), .iss_rk1(iss_rk1), .iss_imm0(iss_imm0), .iss_imm1(iss_imm1),
        .iss_pc0(iss_pc0), .iss_pc1(iss_pc1)
    );

    register_file u_regfile (
        .aclk(aclk), .aresetn(aresetn),
        .iss_en0(iss_en0), .iss_en1(iss_en1), .iss_op0(iss_op0), .iss_op1(iss_op1),
        .iss_rd0(iss_rd0), .iss_rd1(iss_rd1), .iss_rj0(iss_rj0), .iss_rj1(iss_rj1),
        .iss_rk0(iss_rk0), .iss_rk1(iss_rk1), .iss_imm0(iss_imm0), .iss_imm1(iss_imm1),
        .iss_pc0(iss_pc0), .iss_pc1(iss_pc1),
        .wen0(wen0), .wen1(wen1), .waddr0(waddr0), .waddr1(waddr1),
        .wdata0(wdata0), .wdata1(wdata1), .flush(redirect),
        .rf_en0(rf_en0), .rf_en1(rf_en1), .rf_op0(rf_op0), .rf_op1(rf_op1),
        .rf_rd0(rf_rd0), .rf_rd1(rf_rd1), .rf_imm0(rf_imm0), .rf_imm1(rf_imm1),
        .rf_pc0(rf_pc0), .rf_pc1(rf_pc1),
        .rf_dataj0(rf_dataj0), .rf_datak0(rf_datak0),
        .rf_dataj1(rf_dataj1), .rf_datak1(rf_datak1)
    );

    alu_exe u_exe (
        .aclk(aclk), .aresetn(aresetn),
        .rf_en0(rf_en0), .rf_en1(rf_en1), .rf_op0(rf_op0), .rf_op1(rf_op1),
        .rf_rd0(rf_rd0), .rf_rd1(rf_rd1), .rf_imm0(rf_imm0), .rf_imm1(rf_imm1),
        .rf_pc0(rf_pc0), .rf_pc1(rf_pc1),
        .rf_dataj0(rf_dataj0), .rf_datak0(rf_datak0),
        .rf_dataj1(rf_dataj1), .rf_datak1(rf_datak1),
        .ex_en0(ex_en0), .ex_en1(ex_en1), .ex_rd0(ex_rd0), .ex_rd1(ex_rd1),
        .ex_data0(ex_data0), .ex_data1(ex_data1), .ex_pc0(ex_pc0), .ex_pc1(ex_pc1),
        .redirect(redirect), .redirect_pc(redirect_pc)
    );

    writeback u_wb (
        .aclk(aclk), .aresetn(aresetn),
        .ex_en0(ex_en0), .ex_en1(ex_en1), .ex_rd0(ex_rd0), .ex_rd1(ex_rd1),
        .ex_data0(ex_data0), .ex_data1(ex_data1), .ex_pc0(ex_pc0), .ex_pc1(ex_pc1),
        .wen0(wen0), .wen1(wen1), .waddr0(waddr0), .waddr1(waddr1),
        .wdata0(wdata0), .wdata1(wdata1), .release_mask(release_mask),
        .wb_valid0(wb_valid0), .wb_valid1(wb_valid1), .wb_rd0(wb_rd0), .wb_rd1(wb_rd1),
        .wb_data0(wb_data0), .wb_data1(wb_data1), .wb_pc0(wb_pc0), .wb_pc1(wb_pc1)
    );

endmodule

// File: design/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// data and pc width
`define XLEN 32

// architectural registers, r0 included
`define NUM_REGS 32

// issue queue entries, must stay a power of two
`define QUEUE_DEPTH 8

// byte distance between sequential ops
`define PC_STEP 4

`endif

// File: design/issue_queue.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module issue_queue (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic [1:0]                in_num,
    input  uop_pkg::uop_op_t          in_op0,
    input  uop_pkg::uop_op_t          in_op1,
    input  uop_pkg::reg_idx_t         in_rd0, in_rj0, in_rk0,
    input  uop_pkg::reg_idx_t         in_rd1, in_rj1, in_rk1,
    input  result_pkg::word_t         in_imm0, in_imm1,
    input  result_pkg::word_t         in_pc0, in_pc1,
    input  logic                      flush,
    input  result_pkg::pending_mask_t release_mask,
    output logic                      full,
    output logic                      iss_en0, iss_en1,
    output uop_pkg::uop_op_t          iss_op0, iss_op1,
    output uop_pkg::reg_idx_t         iss_rd0, iss_rd1,
    output uop_pkg::reg_idx_t         iss_rj0, iss_rj1,
    output uop_pkg::reg_idx_t         iss_rk0, iss_rk1,
    output result_pkg::word_t         iss_imm0, iss_imm1,
    output result_pkg::word_t         iss_pc0, iss_pc1
);
    import uop_pkg::*;
    import result_pkg::*;

    localparam int DEPTH = `QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    uop_op_t  q_op  [DEPTH];
    reg_idx_t q_rd  [DEPTH];
    reg_idx_t q_rj  [DEPTH];
    reg_idx_t q_rk  [DEPTH];
    word_t    q_imm [DEPTH];
    word_t    q_pc  [DEPTH];

    logic [PTR_W-1:0] head, tail;
    logic [PTR_W-1:0] head_nx, tail_nx;
    logic [CNT_W-1:0] count;
    pending_mask_t    pending;
    pending_mask_t    pend_eff, set_mask;

    logic [1:0] acc_num, iss_num;
    uop_op_t    h0_op, h1_op;
    reg_idx_t   h0_rd, h0_rj, h0_rk;
    reg_idx_t   h1_rd, h1_rj, h1_rk;
    logic       h0_wr, h1_wr, h0_busy, h1_busy;
    logic       can0, can1;

    // keep room for a full pair of incoming ops
    assign full    = count > CNT_W'(DEPTH - 2);
    assign acc_num = (flush || full) ? 2'd0 : (in_num[1] ? 2'd2 : in_num);
    assign head_nx = head + PTR_W'(1);
    assign tail_nx = tail + PTR_W'(1);

    always_comb begin
        h0_op = q_op[head];
        h0_rd = q_rd[head];
        h0_rj = q_rj[head];
        h0_rk = q_rk[head];
        h1_op = q_op[head_nx];
        h1_rd = q_rd[head_nx];
        h1_rj = q_rj[head_nx];
        h1_rk = q_rk[head_nx];

        // writebacks of this cycle already count as done
        pend_eff    = pending & ~release_mask;
        pend_eff[0] = 1'b0;

        h0_wr   = writes_rd(h0_op) && (h0_rd != '0);
        h1_wr   = writes_rd(h1_op) && (h1_rd != '0);
        // rd is checked too so an older release cannot clear a younger mark
        h0_busy = pend_eff[h0_rj] || pend_eff[h0_rk] || (h0_wr && pend_eff[h0_rd]);
        h1_busy = pend_eff[h1_rj] || pend_eff[h1_rk] || (h1_wr && pend_eff[h1_rd]);

        can0 = (count != '0) && !h0_busy;
        can1 = can0 && (count >= CNT_W'(2)) && !h1_busy
            && !is_branch(h0_op) && !is_branch(h1_op)
            && !(h0_wr && ((h1_rj == h0_rd) || (h1_rk == h0_rd)));

        set_mask = '0;
        if (can0 && h0_wr)
            set_mask[h0_rd] = 1'b1;
        if (can1 && h1_wr)
            set_mask[h1_rd] = 1'b1;

        iss_num = {1'b0, can0} + {1'b0, can1};
    end

    always_ff @(posedge aclk) begin
        if (!aresetn || flush) begin
            head    <= '0;
            tail    <= '0;
            count   <= '0;
            pending <= '0;
            iss_en0 <= 1'b0;
            iss_en1 <= 1'b0;
        end else begin
            head    <= head + PTR_W'(iss_num);
            tail    <= tail + PTR_W'(acc_num);
            count   <= count + CNT_W'(acc_num) - CNT_W'(iss_num);
            pending <= pend_eff | set_mask;
            iss_en0 <= can0;
            iss_en1 <= can1;
        end
    end

    // slot 0 is always the older op
    always_ff @(posedge aclk) begin
        if (acc_num != 2'd0) begin
            q_op[tail]  <= in_op0;
            q_rd[tail]  <= in_rd0;
            q_rj[tail]  <= in_rj0;
            q_rk[tail]  <= in_rk0;
            q_imm[tail] <= in_imm0;
            q_pc[tail]  <= in_pc0;
        end
        if (acc_num == 2'd2) begin
            q_op[tail_nx]  <= in_op1;
            q_rd[tail_nx]  <= in_rd1;
            q_rj[tail_nx]  <= in_rj1;
            q_rk[tail_nx]  <= in_rk1;
            q_imm[tail_nx] <= in_imm1;
            q_pc[tail_nx]  <= in_pc1;
        end
    end

    always_ff @(posedge aclk) begin
        iss_op0  <= h0_op;
        iss_rd0  <= h0_rd;
        iss_rj0  <= h0_rj;
        iss_rk0  <= h0_rk;
        iss_imm0 <= q_imm[head];
        iss_pc0  <= q_pc[head];
        iss_op1  <= h1_op;
        iss_rd1  <= h1_rd;
        iss_rj1  <= h1_rj;
        iss_rk1  <= h1_rk;
        iss_imm1 <= q_imm[head_nx];
        iss_pc1  <= q_pc[head_nx];
    end

endmodule

// File: design/register_file.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module register_file (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              iss_en0, iss_en1,
    input  uop_pkg::uop_op_t  iss_op0, iss_op1,
    input  uop_pkg::reg_idx_t iss_rd0, iss_rd1,
    input  uop_pkg::reg_idx_t iss_rj0, iss_rj1,
    input  uop_pkg::reg_idx_t iss_rk0, iss_rk1,
    input  result_pkg::word_t iss_imm0, iss_imm1,
    input  result_pkg::word_t iss_pc0, iss_pc1,
    input  logic              wen0, wen1,
    input  uop_pkg::reg_idx_t waddr0, waddr1,
    input  result_pkg::word_t wdata0, wdata1,
    input  logic              flush,
    output logic              rf_en0, rf_en1,
    output uop_pkg::uop_op_t  rf_op0, rf_op1,
    output uop_pkg::reg_idx_t rf_rd0, rf_rd1,
    output result_pkg::word_t rf_imm0, rf_imm1,
    output result_pkg::word_t rf_pc0, rf_pc1,
    output result_pkg::word_t rf_dataj0, rf_datak0,
    output result_pkg::word_t rf_dataj1, rf_datak1
);
    import uop_pkg::*;
    import result_pkg::*;

    word_t regs [`NUM_REGS];

    // same-cycle writes are forwarded, lane 1 is the younger writer
    function automatic word_t read_port(input reg_idx_t idx);
        word_t val;
        if (idx == '0)
            val = '0;
        else if (wen1 && (waddr1 == idx))
            val = wdata1;
        else if (wen0 && (waddr0 == idx))
            val = wdata0;
        else
            val = regs[idx];
        return val;
    endfunction

    // r0 is never written
    always_ff @(posedge aclk) begin
        if (wen0 && (waddr0 != '0))
            regs[waddr0] <= wdata0;
        if (wen1 && (waddr1 != '0))
            regs[waddr1] <= wdata1;
    end

    always_ff @(posedge aclk) begin
        if (!aresetn || flush) begin
            rf_en0 <= 1'b0;
            rf_en1 <= 1'b0;
        end else begin
            rf_en0 <= iss_en0;
            rf_en1 <= iss_en1;
        end
    end

    // operand stage
    always_ff @(posedge aclk) begin
        rf_op0    <= iss_op0;
        rf_rd0    <= iss_rd0;
        rf_imm0   <= iss_imm0;
        rf_pc0    <= iss_pc0;
        rf_dataj0 <= read_port(iss_rj0);
        rf_datak0 <= read_port(iss_rk0);
        rf_op1    <= iss_op1;
        rf_rd1    <= iss_rd1;
        rf_imm1   <= iss_imm1;
        rf_pc1    <= iss_pc1;
        rf_dataj1 <= read_port(iss_rj1);
        rf_datak1 <= read_port(iss_rk1);
    end

endmodule

// File: design/result_pkg.sv
`include "core_consts.svh"

package result_pkg;

    // machine word, also carries pcs and immediates
    typedef logic [`XLEN-1:0] word_t;

    // one bit per register still waiting for its writeback
    typedef logic [`NUM_REGS-1:0] pending_mask_t;

endpackage

// File: design/uop_pkg.sv
`include "core_consts.svh"

package uop_pkg;

    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_sll  = 4'd5,
        op_srl  = 4'd6,
        op_slt  = 4'd7,
        op_addi = 4'd8,
        op_lui  = 4'd9,
        op_beq  = 4'd10,
        op_bne  = 4'd11,
        op_blt  = 4'd12,
        op_nop  = 4'd13
    } uop_op_t;

    typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

    // conditional branches, resolved in lane 0 only
    function automatic logic is_branch(input uop_op_t op);
        return op inside {op_beq, op_bne, op_blt};
    endfunction

    function automatic logic writes_rd(input uop_op_t op);
        return !is_branch(op) && (op != op_nop);
    endfunction

endpackage

// File: design/writeback.sv
`timescale 1ns/1ps

module writeback (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic                      ex_en0, ex_en1,
    input  uop_pkg::reg_idx_t         ex_rd0, ex_rd1,
    input  result_pkg::word_t         ex_data0, ex_data1,
    input  result_pkg::word_t         ex_pc0, ex_pc1,
    output logic                      wen0, wen1,
    output uop_pkg::reg_idx_t         waddr0, waddr1,
    output result_pkg::word_t         wdata0, wdata1,
    output result_pkg::pending_mask_t release_mask,
    output logic                      wb_valid0, wb_valid1,
    output uop_pkg::reg_idx_t         wb_rd0, wb_rd1,
    output result_pkg::word_t         wb_data0, wb_data1,
    output result_pkg::word_t         wb_pc0, wb_pc1
);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wb_valid0 <= 1'b0;
            wb_valid1 <= 1'b0;
        end else begin
            wb_valid0 <= ex_en0;
            wb_valid1 <= ex_en1;
        end
    end

    always_ff @(posedge aclk) begin
        wb_rd0   <= ex_rd0;
        wb_data0 <= ex_data0;
        wb_pc0   <= ex_pc0;
        wb_rd1   <= ex_rd1;
        wb_data1 <= ex_data1;
        wb_pc1   <= ex_pc1;
    end

    // register file write port follows the retire register
    assign wen0   = wb_valid0;
    assign waddr0 = wb_rd0;
    assign wdata0 = wb_data0;
    assign wen1   = wb_valid1;
    assign waddr1 = wb_rd1;
    assign wdata1 = wb_data1;

    always_comb begin
        release_mask = '0;
        if (wb_valid0)
            release_mask[wb_rd0] = 1'b1;
        if (wb_valid1)
            release_mask[wb_rd1] = 1'b1;
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f verilog.f --top-module tb_core_backend \
    -o sim_core_backend || { echo "build failed"; exit 1; }
./obj_dir/sim_core_backend | tee /dev/stderr | grep -F "TEST RESULT: PASS" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb/backend_model.svh
`ifndef BACKEND_MODEL_SVH
`define BACKEND_MODEL_SVH

localparam int PROG_LEN = 64;

uop_op_t  prog_op  [PROG_LEN];
reg_idx_t prog_rd  [PROG_LEN];
reg_idx_t prog_rj  [PROG_LEN];
reg_idx_t prog_rk  [PROG_LEN];
word_t    prog_imm [PROG_LEN];

// retire trace and taken branch targets, in program order
word_t    exp_pc     [$];
reg_idx_t exp_rd     [$];
word_t    exp_data   [$];
word_t    exp_target [$];
int       model_branches;

function automatic int pick(input int n);
    return int'($unsigned($random(seed)) % n);
endfunction

task automatic build_program();
    int k;
    for (int i = 0; i < PROG_LEN; i++) begin
        prog_rd[i]  = reg_idx_t'(pick(8));
        prog_rj[i]  = reg_idx_t'(pick(8));
        prog_rk[i]  = reg_idx_t'(pick(8));
        prog_imm[i] = word_t'($random(seed));
        if (i < 7) begin
            // seed r1 to r7 before anything reads them
            prog_op[i] = op_lui;
            prog_rd[i] = reg_idx_t'(i + 1);
        end else if (pick(6) == 0) begin
            case (pick(3))
                0:       prog_op[i] = op_beq;
                1:       prog_op[i] = op_bne;
                default: prog_op[i] = op_blt;
            endcase
            // forward by one to four ops
            prog_imm[i] = word_t'(`PC_STEP * (1 + pick(4)));
        end else begin
            k = pick(11);
            prog_op[i] = (k == 10) ? op_nop : uop_op_t'(4'(k));
        end
    end
endtask

function automatic word_t alu_ref(input uop_op_t op, input word_t a, input word_t b,
                                  input word_t imm);
    case (op)
        op_add:  return a + b;
        op_sub:  return a - b;
        op_and:  return a & b;
        op_or:   return a | b;
        op_xor:  return a ^ b;
        op_sll:  return a << b[4:0];
        op_srl:  return a >> b[4:0];
        op_slt:  return ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
        op_addi: return a + imm;
        op_lui:  return imm;
        default: return '0;
    endcase
endfunction

task automatic run_model();
    word_t arch [`NUM_REGS];
    word_t a;
    word_t b;
    logic  taken;
    int    idx;
    for (int r = 0; r < `NUM_REGS; r++)
        arch[r] = '0;
    idx = 0;
    model_branches = 0;
    while (idx < PROG_LEN) begin
        a = arch[prog_rj[idx]];
        b = arch[prog_rk[idx]];
        if (prog_op[idx] inside {op_beq, op_bne, op_blt}) begin
            model_branches++;
            case (prog_op[idx])
                op_beq:  taken = (a == b);
                op_bne:  taken = (a != b);
                default: taken = ($signed(a) < $signed(b));
            endcase
            if (taken) begin
                exp_target.push_back(word_t'(idx * `PC_STEP) + prog_imm[idx]);
                idx = idx + int'(prog_imm[idx]) / `PC_STEP;
            end else begin
                idx++;
            end
        end else begin
            // nops and writes to r0 leave no trace
            if (prog_op[idx] != op_nop && prog_rd[idx] != '0) begin
                arch[prog_rd[idx]] = alu_ref(prog_op[idx], a, b, prog_imm[idx]);
                exp_pc.push_back(word_t'(idx * `PC_STEP));
                exp_rd.push_back(prog_rd[idx]);
                exp_data.push_back(arch[prog_rd[idx]]);
            end
            idx++;
        end
    end
endtask

`endif

// File: tb/tb_core_backend.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module tb_core_backend;
    import uop_pkg::*;
    import result_pkg::*;

    localparam int TIMEOUT_CYCLES = 5000;

    logic       aclk;
    logic       aresetn;
    logic [1:0] in_num;
    uop_op_t    in_op0, in_op1;
    reg_idx_t   in_rd0, in_rj0, in_rk0, in_rd1, in_rj1, in_rk1;
    word_t      in_imm0, in_imm1, in_pc0, in_pc1;
    logic       full;
    logic       redirect;
    word_t      redirect_pc;
    logic       wb_valid0, wb_valid1;
    reg_idx_t   wb_rd0, wb_rd1;
    word_t      wb_data0, wb_data1, wb_pc0, wb_pc1;

    integer seed = 32'he5c0_66c1;
    int     value_errs = 0;
    int     other_errs = 0;
    int     ret_ptr = 0;
    int     redir_cnt = 0;
    int     fetch_idx = 0;
    int     cycles = 0;
    int     queued_bound = 0;

    `include "backend_model.svh"

    core_backend uut (
        .aclk(aclk), .aresetn(aresetn), .in_num(in_num),
        .in_op0(in_op0), .in_op1(in_op1),
        .in_rd0(in_rd0), .in_rj0(in_rj0), .in_rk0(in_rk0),
        .in_rd1(in_rd1), .in_rj1(in_rj1), .in_rk1(in_rk1),
        .in_imm0(in_imm0), .in_imm1(in_imm1), .in_pc0(in_pc0), .in_pc1(in_pc1),
        .full(full), .redirect(redirect), .redirect_pc(redirect_pc),
        .wb_valid0(wb_valid0), .wb_valid1(wb_valid1), .wb_rd0(wb_rd0), .wb_rd1(wb_rd1),
        .wb_data0(wb_data0), .wb_data1(wb_data1), .wb_pc0(wb_pc0), .wb_pc1(wb_pc1)
    );

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    function automatic logic trace_drained();
        return fetch_idx >= PROG_LEN && ret_ptr >= exp_pc.size()
            && redir_cnt >= exp_target.size();
    endfunction

    task automatic check_retire(input int lane, input reg_idx_t rd, input word_t data,
                                input word_t pc);
        if (ret_ptr >= exp_pc.size()) begin
            $display("lane %0d retired pc %h past the end of the expected trace", lane, pc);
            other_errs++;
        end else begin
            assert (pc == exp_pc[ret_ptr]) else begin
                $display("ERR wb_pc%0d exp %h got %h", lane, exp_pc[ret_ptr], pc);
                value_errs++;
            end
            assert (rd == exp_rd[ret_ptr]) else begin
                $display("ERR wb_rd%0d exp %h got %h", lane, exp_rd[ret_ptr], rd);
                value_errs++;
            end
            assert (data == exp_data[ret_ptr]) else begin
                $display("ERR wb_data%0d exp %h got %h", lane, exp_data[ret_ptr], data);
                value_errs++;
            end
            ret_ptr++;
        end
    endtask

    // lane 0 is the older op of a pair
    always @(negedge aclk) begin
        if (aresetn) begin
            if (wb_valid0)
                check_retire(0, wb_rd0, wb_data0, wb_pc0);
            if (wb_valid1)
                check_retire(1, wb_rd1, wb_data1, wb_pc1);
            if (redirect) begin
                if (redir_cnt >= exp_target.size()) begin
                    $display("redirect to %h that the model never takes", redirect_pc);
                    other_errs++;
                end else begin
                    assert (redirect_pc == exp_target[redir_cnt]) else begin
                        $display("ERR redirect_pc exp %h got %h",
                                 exp_target[redir_cnt], redirect_pc);
                        value_errs++;
                    end
                end
                redir_cnt++;
            end
            // full needs enough ops accepted since the last flush
            if (full) begin
                assert (queued_bound > `QUEUE_DEPTH - 2) else begin
                    $display("ERR full exp %h got %h", 1'b0, full);
                    value_errs++;
                end
            end
            if (redirect)
                queued_bound = 0;
            else if (!full)
                queued_bound += int'(in_num);
        end
    end

    task automatic feed_front_end();
        int n;
        if (redirect) begin
            // ops offered now would be dropped anyway
            fetch_idx = int'(redirect_pc / `PC_STEP);
            n = 0;
        end else if (full) begin
            n = 0;
        end else begin
            n = pick(3);
            if (fetch_idx + n > PROG_LEN)
                n = (fetch_idx < PROG_LEN) ? PROG_LEN - fetch_idx : 0;
        end
        if (n > 0) begin
            in_op0  = prog_op[fetch_idx];
            in_rd0  = prog_rd[fetch_idx];
            in_rj0  = prog_rj[fetch_idx];
            in_rk0  = prog_rk[fetch_idx];
            in_imm0 = prog_imm[fetch_idx];
            in_pc0  = word_t'(fetch_idx * `PC_STEP);
        end
        if (n > 1) begin
            in_op1  = prog_op[fetch_idx + 1];
            in_rd1  = prog_rd[fetch_idx + 1];
            in_rj1  = prog_rj[fetch_idx + 1];
            in_rk1  = prog_rk[fetch_idx + 1];
            in_imm1 = prog_imm[fetch_idx + 1];
            in_pc1  = word_t'((fetch_idx + 1) * `PC_STEP);
        end
        in_num = 2'(n);
        fetch_idx += n;
    endtask

    initial begin
        aresetn = 1'b0;
        in_num  = 2'd0;
        in_op0  = op_nop;
        in_op1  = op_nop;
        in_rd0  = '0;
        in_rj0  = '0;
        in_rk0  = '0;
        in_rd1  = '0;
        in_rj1  = '0;
        in_rk1  = '0;
        in_imm0 = '0;
        in_imm1 = '0;
        in_pc0  = '0;
        in_pc1  = '0;
        build_program();
        run_model();
        repeat (8) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        while (!trace_drained() && cycles < TIMEOUT_CYCLES) begin
            @(posedge aclk);
            #1;
            cycles++;
            feed_front_end();
        end
        if (!trace_drained()) begin
            $display("trace did not drain within %0d cycles", TIMEOUT_CYCLES);
            other_errs++;
        end
        in_num = 2'd0;
        // longer than the pipeline, so a stray retire or redirect still shows up
        repeat (8) @(posedge aclk);
        assert (ret_ptr == exp_pc.size()) else begin
            $display("ERR retire_count exp %h got %h", exp_pc.size(), ret_ptr);
            value_errs++;
        end
        assert (redir_cnt == exp_target.size()) else begin
            $display("ERR redirect_count exp %h got %h", exp_target.size(), redir_cnt);
            value_errs++;
        end
        // the queue is empty once everything has drained
        assert (!full) else begin
            $display("ERR full exp %h got %h", 1'b0, full);
            value_errs++;
        end
        $display("model ran %0d branches, %0d taken, %0d writers", model_branches,
                 exp_target.size(), exp_pc.size());
        $display("errors: value %0d, other %0d", value_errs, other_errs);
        if (value_errs + other_errs == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+design
+incdir+tb
design/uop_pkg.sv
design/result_pkg.sv
design/issue_queue.sv
design/register_file.sv
design/alu_exe.sv
design/writeback.sv
design/core_backend.sv
tb/tb_core_backend.sv
